// File: logic/mecobo_pkg.sv
`default_nettype none

package mecobo_pkg;

  // host and bus word widths
  typedef logic [15:0] word_t;
  typedef logic [31:0] time_t;
  typedef logic [15:0] unit_addr_t;
  typedef logic [31:0] cmd_data_t;

  // channel[15:11], value[10], clock[9:0]
  typedef logic [15:0] sample_t;

  // one queued command, 80 bits
  typedef struct packed {
    time_t      start_time;
    unit_addr_t addr;
    cmd_data_t  data;
  } command_t;

  // broadcast command bus, single writer
  typedef struct packed {
    logic       en;
    unit_addr_t addr;
    cmd_data_t  data;
  } cmd_bus_t;

  typedef struct packed {
    logic       wr;
    logic [3:0] addr;
    word_t      data;
  } host_req_t;

  typedef enum logic [1:0] {
    mode_low,
    mode_high,
    mode_square,
    mode_sample
  } pin_mode_e;

  typedef enum logic [1:0] {
    pin_idle,
    pin_run,
    pin_hold
  } pin_state_e;

  // pin register index, low nibble of the unit address
  localparam logic [3:0] reg_mode   = 4'd0;
  localparam logic [3:0] reg_period = 4'd1;

  // host register map
  localparam logic [3:0] host_time_lo      = 4'd0;
  localparam logic [3:0] host_time_hi      = 4'd1;
  localparam logic [3:0] host_addr         = 4'd2;
  localparam logic [3:0] host_data_lo      = 4'd3;
  localparam logic [3:0] host_data_hi      = 4'd4;
  localparam logic [3:0] host_sample_pop   = 4'd8;
  localparam logic [3:0] host_sample_count = 4'd9;
  localparam logic [3:0] host_clock_lo     = 4'd10;
  localparam logic [3:0] host_clock_hi     = 4'd11;
  localparam logic [3:0] host_soft_reset   = 4'd12;

endpackage

`default_nettype wire

// File: logic/sync_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 8
) (
  input  wire                         sys_clk,
  input  wire                         mecobo_reset,
  input  wire                         push,
  input  wire [WIDTH-1:0]             din,
  input  wire                         pop,
  output logic [WIDTH-1:0]            dout,
  output logic                        empty,
  output logic                        full,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = count == '0;
  assign full    = count == CW'(DEPTH);

  // head word is visible without a read strobe
  assign dout = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  a_push_full: assert property (@(posedge sys_clk) disable iff (mecobo_reset) !(push && full));
  a_pop_empty: assert property (@(posedge sys_clk) disable iff (mecobo_reset) !(pop && empty));

endmodule

`default_nettype wire

// File: logic/host_port.sv
`default_nettype none
`timescale 1ns/100ps

module host_port (
  input  wire                  sys_clk,
  input  wire                  mecobo_reset,
  input  mecobo_pkg::host_req_t host_req,
  input  wire                  host_req_valid,
  output logic                 host_req_ready,
  output logic                 host_rsp_valid,
  output mecobo_pkg::word_t    host_rsp_data,
  input  wire                  cmd_full,
  output logic                 cmd_push,
  output mecobo_pkg::command_t cmd_entry,
  input  mecobo_pkg::sample_t  sample_data,
  input  wire                  sample_empty,
  input  wire [4:0]            sample_count,
  output logic                 sample_pop,
  output mecobo_pkg::time_t    global_clock,
  output logic                 soft_reset
);

  logic                   accept;
  logic                   wr_acc;
  logic                   rd_acc;
  mecobo_pkg::word_t      time_lo_q;
  mecobo_pkg::word_t      time_hi_q;
  mecobo_pkg::unit_addr_t addr_q;
  mecobo_pkg::word_t      data_lo_q;
  mecobo_pkg::word_t      rd_data;

  // only the push write can stall
  assign host_req_ready = !(host_req.wr && host_req.addr == mecobo_pkg::host_data_hi && cmd_full);
  assign accept = host_req_valid && host_req_ready;
  assign wr_acc = accept && host_req.wr;
  assign rd_acc = accept && !host_req.wr;

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      global_clock <= '0;
    end else begin
      global_clock <= global_clock + 32'd1;
    end
  end

  // shadow words of the command being assembled
  always_ff @(posedge sys_clk) begin
    if (wr_acc) begin
      case (host_req.addr)
        mecobo_pkg::host_time_lo: time_lo_q <= host_req.data;
        mecobo_pkg::host_time_hi: time_hi_q <= host_req.data;
        mecobo_pkg::host_addr:    addr_q    <= host_req.data;
        mecobo_pkg::host_data_lo: data_lo_q <= host_req.data;
        default: ;
      endcase
    end
  end

  // data high word comes straight from the pushing write
  assign cmd_push = wr_acc && host_req.addr == mecobo_pkg::host_data_hi;
  assign cmd_entry = '{start_time: {time_hi_q, time_lo_q},
                       addr:       addr_q,
                       data:       {host_req.data, data_lo_q}};

  assign sample_pop = rd_acc && host_req.addr == mecobo_pkg::host_sample_pop && !sample_empty;

  always_comb begin
    case (host_req.addr)
      mecobo_pkg::host_sample_pop:   rd_data = sample_empty ? 16'h0000 : sample_data;
      mecobo_pkg::host_sample_count: rd_data = {11'd0, sample_count};
      mecobo_pkg::host_clock_lo:     rd_data = global_clock[15:0];
      mecobo_pkg::host_clock_hi:     rd_data = global_clock[31:16];
      default:                       rd_data = 16'h0000;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      host_rsp_valid <= 1'b0;
      soft_reset     <= 1'b0;
    end else begin
      host_rsp_valid <= rd_acc;
      soft_reset     <= wr_acc && host_req.addr == mecobo_pkg::host_soft_reset;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rd_acc) begin
      host_rsp_data <= rd_data;
    end
  end

  a_no_push_full: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    !(cmd_push && cmd_full));

endmodule

`default_nettype wire

// File: logic/scheduler.sv
`default_nettype none
`timescale 1ns/100ps

module scheduler (
  input  wire                  sys_clk,
  input  wire                  mecobo_reset,
  input  mecobo_pkg::time_t    global_clock,
  input  wire                  cmd_empty,
  input  mecobo_pkg::command_t cmd_head,
  output logic                 cmd_pop,
  output mecobo_pkg::cmd_bus_t cmd_bus
);

  logic                   due;
  logic                   bus_en;
  mecobo_pkg::unit_addr_t bus_addr;
  mecobo_pkg::cmd_data_t  bus_data;

  // head is due once its stamp has been reached
  assign due = !cmd_empty && (cmd_head.start_time <= global_clock);

  // a busy bus cycle blocks the next pop, so one command per two cycles
  assign cmd_pop = due && !bus_en;

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      bus_en <= 1'b0;
    end else begin
      bus_en <= cmd_pop;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (cmd_pop) begin
      bus_addr <= cmd_head.addr;
      bus_data <= cmd_head.data;
    end
  end

  always_comb begin
    cmd_bus.en   = bus_en;
    cmd_bus.addr = bus_addr;
    cmd_bus.data = bus_data;
  end

  // spacing seen by the pin controllers
  a_bus_spacing: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    cmd_bus.en |=> !cmd_bus.en);

endmodule

`default_nettype wire

// File: logic/pin_control.sv
`default_nettype none
`timescale 1ns/100ps

module pin_control #(
  parameter int POSITION = 0
) (
  input  wire                  sys_clk,
  input  wire                  mecobo_reset,
  input  mecobo_pkg::cmd_bus_t cmd_bus,
  input  mecobo_pkg::time_t    global_clock,
  input  wire                  pin_in,
  input  wire                  sample_ready,
  output logic                 pin_out,
  output logic                 pin_oe,
  output logic                 sample_valid,
  output mecobo_pkg::sample_t  sample_data
);

  localparam logic [11:0] UNIT    = 12'(POSITION);
  localparam logic [4:0]  CHANNEL = 5'(POSITION);

  mecobo_pkg::pin_state_e state;
  mecobo_pkg::pin_mode_e  mode;
  mecobo_pkg::pin_mode_e  new_mode;
  mecobo_pkg::cmd_data_t  period;
  mecobo_pkg::cmd_data_t  eff_period;
  mecobo_pkg::cmd_data_t  cnt;
  logic                   hit;
  logic                   mode_wr;
  logic                   period_wr;
  logic                   tick;

  assign hit       = cmd_bus.en && cmd_bus.addr[15:4] == UNIT;
  assign mode_wr   = hit && cmd_bus.addr[3:0] == mecobo_pkg::reg_mode;
  assign period_wr = hit && cmd_bus.addr[3:0] == mecobo_pkg::reg_period;
  assign new_mode  = mecobo_pkg::pin_mode_e'(cmd_bus.data[1:0]);

  // zero period runs as one cycle
  assign eff_period = (period == '0) ? 32'd1 : period;
  assign tick       = (state != mecobo_pkg::pin_idle) && (cnt == eff_period - 32'd1);

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      state   <= mecobo_pkg::pin_idle;
      mode    <= mecobo_pkg::mode_low;
      period  <= '0;
      cnt     <= '0;
      pin_out <= 1'b0;
    end else begin
      if (mode_wr) begin
        mode    <= new_mode;
        pin_out <= (new_mode == mecobo_pkg::mode_high);
      end else if (tick && mode == mecobo_pkg::mode_square) begin
        pin_out <= ~pin_out;
      end
      if (period_wr) begin
        period <= cmd_bus.data;
      end
      // restart the period on any register write
      if (mode_wr || period_wr || tick) begin
        cnt <= '0;
      end else if (state != mecobo_pkg::pin_idle) begin
        cnt <= cnt + 32'd1;
      end
      case (state)
        mecobo_pkg::pin_idle: begin
          if (mode_wr) begin
            state <= mecobo_pkg::pin_run;
          end
        end
        mecobo_pkg::pin_run: begin
          if (tick && mode == mecobo_pkg::mode_sample && !mode_wr) begin
            state <= mecobo_pkg::pin_hold;
          end
        end
        mecobo_pkg::pin_hold: begin
          // ticks here are dropped
          if (sample_ready) begin
            state <= mecobo_pkg::pin_run;
          end
        end
        default: state <= mecobo_pkg::pin_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == mecobo_pkg::pin_run && tick && mode == mecobo_pkg::mode_sample) begin
      sample_data <= {CHANNEL, pin_in, global_clock[9:0]};
    end
  end

  assign sample_valid = (state == mecobo_pkg::pin_hold);
  assign pin_oe = (state != mecobo_pkg::pin_idle) && (mode != mecobo_pkg::mode_sample);

  a_sample_stable: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample_data)));

endmodule

`default_nettype wire

// File: logic/sample_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module sample_arbiter #(
  parameter int NUM_PINS = 4
) (
  input  wire                                sys_clk,
  input  wire                                mecobo_reset,
  input  wire [NUM_PINS-1:0]                 req_valid,
  input  mecobo_pkg::sample_t [NUM_PINS-1:0] req_data,
  output logic [NUM_PINS-1:0]                req_ready,
  input  wire                                fifo_full,
  output logic                               fifo_push,
  output mecobo_pkg::sample_t                fifo_data
);

  localparam int PW = (NUM_PINS > 1) ? $clog2(NUM_PINS) : 1;

  logic [PW-1:0] ptr;
  logic [PW-1:0] win;
  logic          found;

  // first valid requester at or after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    win   = '0;
    for (int i = 0; i < NUM_PINS; i++) begin
      idx = int'(ptr) + i;
      if (idx >= NUM_PINS) begin
        idx = idx - NUM_PINS;
      end
      if (!found && req_valid[idx]) begin
        found = 1'b1;
        win   = PW'(idx);
      end
    end
  end

  assign fifo_push = found && !fifo_full;
  assign fifo_data = req_data[win];

  always_comb begin
    req_ready = '0;
    req_ready[win] = fifo_push;
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      ptr <= '0;
    end else if (fifo_push) begin
      ptr <= (win == PW'(NUM_PINS - 1)) ? '0 : win + 1'b1;
    end
  end

  a_grant_onehot: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    $onehot0(req_ready));

endmodule

`default_nettype wire

// File: logic/mecobo_core.sv
`default_nettype none
`timescale 1ns/100ps

module mecobo_core #(
  parameter int NUM_PINS     = 4,
  parameter int CMD_DEPTH    = 8,
  parameter int SAMPLE_DEPTH = 16
) (
  input  wire                   sys_clk,
  input  wire                   mecobo_reset,
  input  mecobo_pkg::host_req_t host_req,
  input  wire                   host_req_valid,
  output logic                  host_req_ready,
  output logic                  host_rsp_valid,
  output mecobo_pkg::word_t     host_rsp_data,
  input  wire [NUM_PINS-1:0]    pin_in,
  output logic [NUM_PINS-1:0]   pin_out,
  output logic [NUM_PINS-1:0]   pin_oe
);

  logic                               unit_reset;
  logic                               soft_reset;
  mecobo_pkg::time_t                  global_clock;
  logic                               cmd_push;
  logic                               cmd_pop;
  logic                               cmd_full;
  logic                               cmd_empty;
  mecobo_pkg::command_t               cmd_entry;
  mecobo_pkg::command_t               cmd_head;
  mecobo_pkg::cmd_bus_t               cmd_bus;
  logic                               sample_push;
  logic                               sample_pop;
  logic                               sample_full;
  logic                               sample_empty;
  logic [4:0]                         sample_count;
  mecobo_pkg::sample_t                sample_in;
  mecobo_pkg::sample_t                sample_head;
  logic [NUM_PINS-1:0]                sample_valid;
  logic [NUM_PINS-1:0]                sample_ready;
  mecobo_pkg::sample_t [NUM_PINS-1:0] sample_data;

  // soft reset clears the command and sample paths, not the clock
  assign unit_reset = mecobo_reset | soft_reset;

  host_port u_host_port (
    .sys_clk        (sys_clk),
    .mecobo_reset   (mecobo_reset),
    .host_req       (host_req),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp_data  (host_rsp_data),
    .cmd_full       (cmd_full),
    .cmd_push       (cmd_push),
    .cmd_entry      (cmd_entry),
    .sample_data    (sample_head),
    .sample_empty   (sample_empty),
    .sample_count   (sample_count),
    .sample_pop     (sample_pop),
    .global_clock   (global_clock),
    .soft_reset     (soft_reset)
  );

  sync_fifo #(.WIDTH($bits(mecobo_pkg::command_t)), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
    .sys_clk      (sys_clk),
    .mecobo_reset (unit_reset),
    .push         (cmd_push),
    .din          (cmd_entry),
    .pop          (cmd_pop),
    .dout         (cmd_head),
    .empty        (cmd_empty),
    .full         (cmd_full),
    .count        ()
  );

  scheduler u_scheduler (
    .sys_clk      (sys_clk),
    .mecobo_reset (unit_reset),
    .global_clock (global_clock),
    .cmd_empty    (cmd_empty),
    .cmd_head     (cmd_head),
    .cmd_pop      (cmd_pop),
    .cmd_bus      (cmd_bus)
  );

  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    pin_control #(.POSITION(i)) u_pin (
      .sys_clk      (sys_clk),
      .mecobo_reset (unit_reset),
      .cmd_bus      (cmd_bus),
      .global_clock (global_clock),
      .pin_in       (pin_in[i]),
      .sample_ready (sample_ready[i]),
      .pin_out      (pin_out[i]),
      .pin_oe       (pin_oe[i]),
      .sample_valid (sample_valid[i]),
      .sample_data  (sample_data[i])
    );
  end

  sample_arbiter #(.NUM_PINS(NUM_PINS)) u_arbiter (
    .sys_clk      (sys_clk),
    .mecobo_reset (unit_reset),
    .req_valid    (sample_valid),
    .req_data     (sample_data),
    .req_ready    (sample_ready),
    .fifo_full    (sample_full),
    .fifo_push    (sample_push),
    .fifo_data    (sample_in)
  );

  sync_fifo #(.WIDTH($bits(mecobo_pkg::sample_t)), .DEPTH(SAMPLE_DEPTH)) u_sample_fifo (
    .sys_clk      (sys_clk),
    .mecobo_reset (unit_reset),
    .push         (sample_push),
    .din          (sample_in),
    .pop          (sample_pop),
    .dout         (sample_head),
    .empty        (sample_empty),
    .full         (sample_full),
    .count        (sample_count)
  );

endmodule

`default_nettype wire

// File: verif/mecobo_tb.sv
`default_nettype none
`timescale 1ns/100ps

module mecobo_tb;

  localparam int NUM_PINS  = 4;
  localparam int CMD_DEPTH = 8;
  localparam int TIMEOUT   = 64;

  logic                  sys_clk;
  logic                  mecobo_reset;
  mecobo_pkg::host_req_t host_req;
  logic                  host_req_valid;
  logic                  host_req_ready;
  logic                  host_rsp_valid;
  mecobo_pkg::word_t     host_rsp_data;
  logic [NUM_PINS-1:0]   pin_in;
  logic [NUM_PINS-1:0]   pin_out;
  logic [NUM_PINS-1:0]   pin_oe;

  int          cycle = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          checks = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  string       current_test = "";
  logic [15:0] lfsr_state = 16'd20529;

  // pending comparisons for the compare process
  string       label_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];
  string       cmp_label;
  logic [31:0] cmp_exp;
  logic [31:0] cmp_act;

  mecobo_core #(.NUM_PINS(NUM_PINS), .CMD_DEPTH(CMD_DEPTH), .SAMPLE_DEPTH(16)) UUT (
    .sys_clk        (sys_clk),
    .mecobo_reset   (mecobo_reset),
    .host_req       (host_req),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp_data  (host_rsp_data),
    .pin_in         (pin_in),
    .pin_out        (pin_out),
    .pin_oe         (pin_oe)
  );

  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) cycle <= cycle + 1;

  always @(negedge sys_clk) begin
    while (act_q.size() > 0) begin
      cmp_label = label_q.pop_front();
      cmp_exp   = exp_q.pop_front();
      cmp_act   = act_q.pop_front();
      checks++;
      assert (cmp_act === cmp_exp) else begin
        $display("Error %s, %s: expected %0h, actual %0h",
                 current_test, cmp_label, cmp_exp, cmp_act);
        errors++;
        test_errors++;
      end
    end
  end

  // galois step for taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // reference model
  function automatic logic [31:0] expected_interval(input int period);
    return (period == 0) ? 32'd1 : 32'(period);
  endfunction

  function automatic logic [31:0] expected_sample(input int ch, input logic lvl,
                                                  input logic [9:0] stamp);
    return {16'd0, 5'(ch), lvl, stamp};
  endfunction

  // nearest nonzero multiple of the period at or below the gap
  function automatic logic [31:0] expected_gap(input int period, input int gap);
    int m;
    m = gap / period;
    if (m == 0) begin
      m = 1;
    end
    return 32'(m * period);
  endfunction

  task automatic queue_check(input string label, input logic [31:0] e, input logic [31:0] a);
    label_q.push_back(label);
    exp_q.push_back(e);
    act_q.push_back(a);
  endtask

  task automatic note_problem(input string msg);
    $display("%s: %s", current_test, msg);
    errors++;
    test_errors++;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge sys_clk);
    #2;
  endtask

  task automatic start_test(input string name);
    current_test = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    idle(2);
    assert (act_q.size() == 0) else note_problem("comparisons were left unprocessed");
    if (test_errors == 0) begin
      $display("%s: ok", current_test);
      tests_passed++;
    end else begin
      $display("%s: %0d error(s)", current_test, test_errors);
      tests_failed++;
    end
  endtask

  // ready sampled at the falling edge before the transfer edge
  task automatic host_write(input logic [3:0] a, input mecobo_pkg::word_t d,
                            input int limit, output bit accepted);
    host_req = '{wr: 1'b1, addr: a, data: d};
    host_req_valid = 1'b1;
    accepted = 1'b0;
    for (int n = 0; n < limit && !accepted; n++) begin
      @(negedge sys_clk);
      accepted = host_req_ready;
      @(posedge sys_clk);
    end
    #2;
    host_req_valid = 1'b0;
  endtask

  task automatic host_read(input logic [3:0] a, output mecobo_pkg::word_t d,
                           output int acc_cycle);
    bit accepted;
    bit got;
    int lat;
    host_req = '{wr: 1'b0, addr: a, data: 16'h0000};
    host_req_valid = 1'b1;
    accepted = 1'b0;
    acc_cycle = 0;
    d = '0;
    for (int n = 0; n < TIMEOUT && !accepted; n++) begin
      @(negedge sys_clk);
      accepted = host_req_ready;
      acc_cycle = cycle;
      @(posedge sys_clk);
    end
    #2;
    host_req_valid = 1'b0;
    assert (accepted) else note_problem("read request was never accepted");
    if (accepted) begin
      got = 1'b0;
      lat = 0;
      while (!got && lat < 4) begin
        @(negedge sys_clk);
        lat++;
        got = host_rsp_valid;
      end
      assert (got) else note_problem("no read response arrived");
      queue_check("read latency", 1, lat);
      d = host_rsp_data;
      @(posedge sys_clk);
      #2;
    end
  endtask

  task automatic read_clock(output logic [31:0] value, output int acc_cycle);
    mecobo_pkg::word_t lo;
    mecobo_pkg::word_t hi;
    int unused;
    host_read(mecobo_pkg::host_clock_lo, lo, acc_cycle);
    host_read(mecobo_pkg::host_clock_hi, hi, unused);
    value = {hi, lo};
  endtask

  task automatic push_command(input logic [31:0] start, input int unit, input logic [3:0] regi,
                              input logic [31:0] data, input int limit, output bit accepted);
    bit ok;
    logic [15:0] a;
    a = {12'(unit), regi};
    host_write(mecobo_pkg::host_time_lo, start[15:0], TIMEOUT, ok);
    assert (ok) else note_problem("time low write was refused");
    host_write(mecobo_pkg::host_time_hi, start[31:16], TIMEOUT, ok);
    assert (ok) else note_problem("time high write was refused");
    host_write(mecobo_pkg::host_addr, a, TIMEOUT, ok);
    assert (ok) else note_problem("address write was refused");
    host_write(mecobo_pkg::host_data_lo, data[15:0], TIMEOUT, ok);
    assert (ok) else note_problem("data low write was refused");
    host_write(mecobo_pkg::host_data_hi, data[31:16], limit, accepted);
  endtask

  task automatic measure_edges(input int pin, input int edges, input int period);
    logic prev;
    int last;
    int seen;
    prev = pin_out[pin];
    last = -1;
    seen = 0;
    for (int n = 0; n < edges * 40 && seen < edges; n++) begin
      @(negedge sys_clk);
      if (pin_out[pin] !== prev) begin
        if (last >= 0) begin
          queue_check("toggle interval", expected_interval(period), cycle - last);
        end
        last = cycle;
        prev = pin_out[pin];
        seen++;
      end
    end
    assert (seen == edges) else note_problem("square wave stopped toggling");
    @(posedge sys_clk);
    #2;
  endtask

  // a level held longer than one period means the square wave has stopped
  task automatic settle_level(input int pin, input logic lvl, input int period);
    int steady;
    steady = 0;
    for (int n = 0; n < TIMEOUT && steady <= period; n++) begin
      @(negedge sys_clk);
      if (pin_out[pin] === lvl) begin
        steady++;
      end else begin
        steady = 0;
      end
    end
    assert (steady > period) else note_problem("pin never settled at the commanded level");
    @(posedge sys_clk);
    #2;
  endtask

  task automatic hold_level(input int pin, input logic lvl, input int span, input string label);
    int changes;
    changes = 0;
    for (int n = 0; n < span; n++) begin
      @(negedge sys_clk);
      if (pin_out[pin] !== lvl || pin_oe[pin] !== 1'b1) begin
        changes++;
      end
    end
    queue_check(label, 0, changes);
    @(posedge sys_clk);
    #2;
  endtask

  task automatic after_reset();
    mecobo_pkg::word_t w;
    int a;
    start_test("after reset");
    @(negedge sys_clk);
    queue_check("output enables", 0, pin_oe);
    queue_check("response valid", 0, host_rsp_valid);
    @(posedge sys_clk);
    #2;
    host_read(mecobo_pkg::host_sample_count, w, a);
    queue_check("sample count", 0, w);
    finish_test();
  endtask

  task automatic clock_counting();
    logic [31:0] c1;
    logic [31:0] c2;
    int a1;
    int a2;
    start_test("global clock");
    read_clock(c1, a1);
    idle(int'(random_bits(3)) + 1);
    read_clock(c2, a2);
    queue_check("clock difference", a2 - a1, c2 - c1);
    finish_test();
  endtask

  task automatic square_wave();
    int p;
    int a;
    bit ok;
    bit rose;
    logic oe_before;
    logic [31:0] c;
    logic [31:0] start;
    start_test("square wave");
    p = int'(random_bits(4)) + 3;
    push_command(0, 1, mecobo_pkg::reg_period, p, TIMEOUT, ok);
    assert (ok) else note_problem("period command was refused");
    read_clock(c, a);
    start = c + 60;
    push_command(start, 1, mecobo_pkg::reg_mode, 32'(mecobo_pkg::mode_square), TIMEOUT, ok);
    assert (ok) else note_problem("mode command was refused");
    c = 0;
    for (int n = 0; n < 100 && c < start; n++) begin
      // enable taken in the same cycle as the clock value
      oe_before = pin_oe[1];
      read_clock(c, a);
      if (c < start) begin
        queue_check("output enable before start", 0, oe_before);
      end
    end
    assert (c >= start) else note_problem("clock read-back never reached the start time");
    rose = 1'b0;
    for (int n = 0; n < TIMEOUT && !rose; n++) begin
      @(negedge sys_clk);
      rose = pin_oe[1];
    end
    assert (rose) else note_problem("output enable never rose");
    @(posedge sys_clk);
    #2;
    measure_edges(1, 5, p);
    push_command(0, 1, mecobo_pkg::reg_mode, 32'(mecobo_pkg::mode_high), TIMEOUT, ok);
    settle_level(1, 1'b1, p);
    hold_level(1, 1'b1, 3 * p, "high level changes");
    push_command(0, 1, mecobo_pkg::reg_mode, 32'(mecobo_pkg::mode_low), TIMEOUT, ok);
    settle_level(1, 1'b0, p);
    hold_level(1, 1'b0, 3 * p, "low level changes");
    finish_test();
  endtask

  task automatic sampling();
    int sp[4];
    logic level[4];
    int seen[4];
    logic [9:0] last_stamp[4];
    logic [9:0] gap;
    mecobo_pkg::word_t w;
    int ch;
    int a;
    bit ok;
    start_test("sampling");
    for (int i = 0; i < 4; i++) begin
      seen[i] = 0;
      last_stamp[i] = '0;
      sp[i] = 1;
      level[i] = 1'b0;
    end
    for (int i = 2; i < 4; i++) begin
      sp[i] = int'(random_bits(4)) + 3;
      level[i] = 1'(random_bits(1));
    end
    pin_in = {level[3], level[2], 2'b00};
    // periods go out before the modes
    for (int i = 2; i < 4; i++) begin
      push_command(0, i, mecobo_pkg::reg_period, sp[i], TIMEOUT, ok);
      assert (ok) else note_problem("period command was refused");
    end
    for (int i = 2; i < 4; i++) begin
      push_command(0, i, mecobo_pkg::reg_mode, 32'(mecobo_pkg::mode_sample), TIMEOUT, ok);
      assert (ok) else note_problem("mode command was refused");
    end
    for (int n = 0; n < 300 && (seen[2] < 6 || seen[3] < 6); n++) begin
      host_read(mecobo_pkg::host_sample_pop, w, a);
      if (w != 16'h0000) begin
        ch = int'(w[15:11]);
        assert (ch == 2 || ch == 3) else
          note_problem($sformatf("sample came from channel %0d, which is not sampling", ch));
        if (ch == 2 || ch == 3) begin
          queue_check("sample word", expected_sample(ch, level[ch], w[9:0]), w);
          if (seen[ch] > 0) begin
            gap = w[9:0] - last_stamp[ch];
            queue_check("sample time gap", expected_gap(sp[ch], gap), gap);
          end
          last_stamp[ch] = w[9:0];
          seen[ch]++;
        end
      end
    end
    assert (seen[2] >= 6 && seen[3] >= 6) else note_problem("too few samples were read back");
    finish_test();
  endtask

  task automatic back_pressure();
    bit ok;
    start_test("back-pressure");
    for (int i = 0; i < CMD_DEPTH; i++) begin
      push_command(32'h4000_0000, 0, mecobo_pkg::reg_mode, 32'(mecobo_pkg::mode_high),
                   TIMEOUT, ok);
      assert (ok) else note_problem("command was refused before the FIFO was full");
    end
    // this one has to time out
    push_command(32'h4000_0000, 0, mecobo_pkg::reg_mode, 32'(mecobo_pkg::mode_high), 20, ok);
    assert (!ok) else note_problem("push was accepted while the command FIFO was full");
    finish_test();
  endtask

  task automatic soft_reset_path();
    mecobo_pkg::word_t w;
    logic [31:0] c1;
    logic [31:0] c2;
    int a;
    int a1;
    int a2;
    bit ok;
    bit oe_clear;
    start_test("soft reset");
    host_read(mecobo_pkg::host_sample_count, w, a);
    assert (w != 16'h0000) else note_problem("sample FIFO was already empty before the reset");
    read_clock(c1, a1);
    host_write(mecobo_pkg::host_soft_reset, 16'h0000, TIMEOUT, ok);
    assert (ok) else note_problem("soft reset write was refused");
    oe_clear = 1'b0;
    for (int n = 0; n < TIMEOUT && !oe_clear; n++) begin
      @(negedge sys_clk);
      oe_clear = (pin_oe == '0);
    end
    queue_check("output enables", 0, pin_oe);
    @(posedge sys_clk);
    #2;
    host_read(mecobo_pkg::host_sample_count, w, a);
    queue_check("sample count", 0, w);
    push_command(32'h4000_0000, 0, mecobo_pkg::reg_mode, 32'(mecobo_pkg::mode_high), 3, ok);
    assert (ok) else note_problem("command FIFO was still full after the reset");
    read_clock(c2, a2);
    queue_check("clock difference", a2 - a1, c2 - c1);
    finish_test();
  endtask

  initial begin
    mecobo_reset   = 1'b1;
    host_req       = '0;
    host_req_valid = 1'b0;
    pin_in         = '0;
    repeat (8) @(posedge sys_clk);
    #2;
    mecobo_reset = 1'b0;
    after_reset();
    clock_counting();
    square_wave();
    sampling();
    back_pressure();
    soft_reset_path();
    $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
logic/mecobo_pkg.sv
logic/sync_fifo.sv
logic/host_port.sv
logic/scheduler.sv
logic/pin_control.sv
logic/sample_arbiter.sv
logic/mecobo_core.sv
verif/mecobo_tb.sv

// File: Bender.yml
package:
  name: mecobo_core

sources:
  - logic/mecobo_pkg.sv
  - logic/sync_fifo.sv
  - logic/host_port.sv
  - logic/scheduler.sv
  - logic/pin_control.sv
  - logic/sample_arbiter.sv
  - logic/mecobo_core.sv
  - target: simulation
    files:
      - verif/mecobo_tb.sv
